/* sim.f */
+incdir+.
rv_core_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core_top.sv
tb_inst_mem.sv
tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - .
    files:
      - rv_core_pkg.sv
      - rv_fetch.sv
      - rv_decode.sv
      - rv_execute.sv
      - rv_result.sv
      - rv_core_top.sv
      - target: simulation
        files:
          - tb_inst_mem.sv
          - tb_rv_core.sv

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module tb_rv_core;

    localparam logic [6:0] OPC_IMM         = 7'b0010011;
    localparam logic [6:0] OPC_JALR        = 7'b1100111;
    localparam int         TIMEOUT         = 2000;
    localparam logic [7:0] FETCH_SIZE      = 8'h0F;
    localparam int         RETIRES_TO_TRAP = 16;  // program order up to the illegal word

    logic                  clk;
    logic                  rst;
    logic                  delay_en;
    logic                  addr_valid;
    logic                  addr_ready;
    logic [`RV_XLEN-1:0]   addr;
    logic [7:0]            size;
    logic                  data_valid;
    logic                  data_ready;
    logic [`RV_XLEN-1:0]   data;
    rv_core_pkg::retire_s  retire;

    logic [31:0]           prog [0:511];
    logic [`RV_XLEN-1:0]   m_regs [0:31];  // architectural model state
    logic [`RV_XLEN-1:0]   m_pc;
    int                    retired;
    logic [31:0]           m_inst;
    logic [`RV_XLEN-1:0]   m_rs1v;
    logic [`RV_XLEN-1:0]   m_rs2v;
    logic [`RV_XLEN-1:0]   m_imm;
    logic [`RV_XLEN-1:0]   m_sum;
    logic [`RV_XLEN-1:0]   m_val;
    logic                  m_legal;
    logic                  m_write;
    logic [4:0]            exp_rd;
    logic [`RV_XLEN-1:0]   exp_wdata;
    logic [`RV_XLEN-1:0]   exp_next;
    int                    errors;
    int                    tests;
    int                    start_errs;

    rv_core_top i_dut (
        .clk             (clk),
        .rst_i           (rst),
        .rd_addr_valid_o (addr_valid),
        .rd_addr_ready_i (addr_ready),
        .rd_addr_o       (addr),
        .rd_size_o       (size),
        .rd_data_valid_i (data_valid),
        .rd_data_ready_o (data_ready),
        .rd_data_i       (data),
        .retire_o        (retire)
    );

    tb_inst_mem i_mem (
        .clk             (clk),
        .rst_i           (rst),
        .delay_i         (delay_en),
        .rd_addr_valid_i (addr_valid),
        .rd_addr_ready_o (addr_ready),
        .rd_addr_i       (addr),
        .rd_data_valid_o (data_valid),
        .rd_data_ready_i (data_ready),
        .rd_data_o       (data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] j_format(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] b_format(input logic [12:0] off, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // ISA reference model for the instruction at m_pc
    always_comb begin
        m_inst   = prog[m_pc[10:2]];
        m_rs1v   = m_regs[m_inst[19:15]];
        m_rs2v   = m_regs[m_inst[24:20]];
        m_imm    = {{52{m_inst[31]}}, m_inst[31:20]};
        m_sum    = m_rs1v + m_imm;
        m_legal  = 1'b1;
        m_write  = 1'b1;
        m_val    = m_pc + 64'd4;  // link value
        exp_next = m_pc + 64'd4;
        case (m_inst[6:0])
            OPC_IMM: begin
                m_legal = (m_inst[14:12] == 3'd0);
                m_val   = m_sum;
            end
            7'b0110011: begin
                m_legal = m_inst[14:12] == 3'd0 && m_inst[31:25] inside {7'h00, 7'h20};
                m_val   = m_inst[30] ? m_rs1v - m_rs2v : m_rs1v + m_rs2v;
            end
            7'b0110111: m_val = {{32{m_inst[31]}}, m_inst[31:12], 12'b0};
            7'b1101111: exp_next = m_pc + {{44{m_inst[31]}}, m_inst[19:12], m_inst[20],
                                           m_inst[30:21], 1'b0};
            OPC_JALR: begin
                m_legal  = (m_inst[14:12] == 3'd0);
                exp_next = {m_sum[`RV_XLEN-1:1], 1'b0};
            end
            7'b1100011: begin
                m_legal = (m_inst[14:13] == 2'd0);
                m_write = 1'b0;
                if ((m_rs1v == m_rs2v) != m_inst[12]) begin
                    exp_next = m_pc + {{52{m_inst[31]}}, m_inst[7], m_inst[30:25],
                                       m_inst[11:8], 1'b0};
                end
            end
            default: m_legal = 1'b0;
        endcase
        if (!m_legal) begin
            m_write  = 1'b0;
            exp_next = `RV_TRAP_VEC;
        end
        exp_rd    = m_write ? m_inst[11:7] : 5'd0;
        exp_wdata = (exp_rd != 5'd0) ? m_val : '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            m_pc    <= `RV_RESET_PC;
            retired <= 0;
            for (int r = 0; r < 32; r++) m_regs[r] <= '0;
        end else if (retire.valid) begin
            if (exp_rd != 5'd0) m_regs[exp_rd] <= exp_wdata;
            m_pc    <= exp_next;
            retired <= retired + 1;
        end
    end

    a_retire_pc: assert property (@(posedge clk) disable iff (rst)
        retire.valid |-> retire.pc == m_pc)
        else begin
            errors++;
            $display("CHECK FAILED at time %0t: retire_o.pc = %h, expected %h",
                     $time, $sampled(retire.pc), $sampled(m_pc));
        end

    a_retire_rd: assert property (@(posedge clk) disable iff (rst)
        retire.valid |-> retire.rd == exp_rd)
        else begin
            errors++;
            $display("CHECK FAILED at time %0t: retire_o.rd = %0d, expected %0d",
                     $time, $sampled(retire.rd), $sampled(exp_rd));
        end

    a_retire_wdata: assert property (@(posedge clk) disable iff (rst)
        retire.valid |-> retire.wdata == exp_wdata)
        else begin
            errors++;
            $display("CHECK FAILED at time %0t: retire_o.wdata = %h, expected %h",
                     $time, $sampled(retire.wdata), $sampled(exp_wdata));
        end

    a_fetch_size: assert property (@(posedge clk) disable iff (rst)
        addr_valid |-> size == FETCH_SIZE)
        else begin
            errors++;
            $display("CHECK FAILED at time %0t: rd_size_o = %h, expected %h",
                     $time, $sampled(size), FETCH_SIZE);
        end

    task automatic wait_retire(input logic [`RV_XLEN-1:0] end_pc);
        int  cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            if (retire.valid && retire.pc == end_pc) done = 1'b1;
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("core hung: pc %h did not retire within %0d cycles", end_pc, TIMEOUT);
        end
    endtask

    task automatic check_retired();
        assert (retired == RETIRES_TO_TRAP)
            else begin
                errors++;
                $display("CHECK FAILED at time %0t: retired count = %0d, expected %0d",
                         $time, retired, RETIRES_TO_TRAP);
            end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("test %0d %s finished with %0d errors", tests, name, errors - errs_before);
    endtask

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    endtask

    initial begin
        errors   = 0;
        tests    = 0;
        rst      = 1'b1;
        delay_en = 1'b0;
        for (int k = 0; k < 512; k++) prog[k] = {k[24:0], 7'b0};  // illegal opcode fill
        prog[0]   = i_format(12'd5, 5'd0, 3'd0, 5'd1, OPC_IMM);
        prog[1]   = i_format(12'd7, 5'd1, 3'd0, 5'd2, OPC_IMM);   // back-to-back on x1
        prog[2]   = r_format(7'h00, 5'd2, 5'd1, 5'd3);
        prog[3]   = r_format(7'h20, 5'd1, 5'd3, 5'd4);            // sub
        prog[4]   = u_format(20'h12345, 5'd5);
        prog[5]   = i_format(12'hfff, 5'd5, 3'd0, 5'd5, OPC_IMM);
        prog[6]   = i_format(12'd3, 5'd1, 3'd0, 5'd0, OPC_IMM);   // write to x0
        prog[7]   = r_format(7'h00, 5'd5, 5'd0, 5'd6);
        prog[8]   = u_format(20'h80000, 5'd7);                    // negative upper immediate
        prog[9]   = b_format(13'd8, 5'd1, 5'd1, 3'd0);            // beq taken
        prog[10]  = i_format(12'd99, 5'd0, 3'd0, 5'd9, OPC_IMM);
        prog[11]  = b_format(13'd8, 5'd1, 5'd1, 3'd1);            // bne not taken
        prog[12]  = i_format(12'd1, 5'd0, 3'd0, 5'd10, OPC_IMM);
        prog[13]  = j_format(21'd8, 5'd11);
        prog[14]  = i_format(12'd98, 5'd0, 3'd0, 5'd9, OPC_IMM);
        prog[15]  = i_format(12'h011, 5'd11, 3'd0, 5'd13, OPC_JALR);  // odd target
        prog[16]  = i_format(12'd97, 5'd0, 3'd0, 5'd9, OPC_IMM);
        prog[17]  = i_format(12'd96, 5'd0, 3'd0, 5'd9, OPC_IMM);
        prog[18]  = i_format(12'd0, 5'd13, 3'd0, 5'd14, OPC_IMM);
        prog[19]  = 32'hffff_ffff;
        prog[256] = i_format(12'd42, 5'd0, 3'd0, 5'd15, OPC_IMM);  // trap handler
        prog[257] = j_format(21'd0, 5'd0);                        // spin
        for (int k = 0; k < 512; k++) i_mem.mem[k] = prog[k];

        @(posedge clk);
        apply_reset();
        start_errs = errors;
        wait_retire(`RV_RESET_PC + 64'd32);
        report_test("arithmetic", start_errs);
        start_errs = errors;
        wait_retire(`RV_RESET_PC + 64'd48);
        report_test("branches", start_errs);
        start_errs = errors;
        wait_retire(`RV_RESET_PC + 64'd72);
        report_test("jumps", start_errs);
        start_errs = errors;
        wait_retire(`RV_TRAP_VEC);
        check_retired();
        report_test("trap", start_errs);

        // same program again with random memory stalls
        start_errs = errors;
        delay_en <= 1'b1;
        apply_reset();
        wait_retire(`RV_TRAP_VEC);
        check_retired();
        report_test("back-pressure", start_errs);

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_inst_mem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module tb_inst_mem (
    input  wire logic                clk,
    input  wire logic                rst_i,
    input  wire logic                delay_i,          // random stalls on both channels
    input  wire logic                rd_addr_valid_i,
    output logic                     rd_addr_ready_o,
    input  wire logic [`RV_XLEN-1:0] rd_addr_i,
    output logic                     rd_data_valid_o,
    input  wire logic                rd_data_ready_i,
    output logic [`RV_XLEN-1:0]      rd_data_o
);

    logic [31:0]         mem [0:511];  // loaded by the testbench
    logic                pending;
    logic [`RV_XLEN-1:0] addr_q;
    int                  wait_cnt;

    // one process so the seeded generator drives every delay
    initial begin
        void'($urandom(87));
        rd_addr_ready_o = 1'b0;
        rd_data_valid_o = 1'b0;
        rd_data_o       = '0;
        pending         = 1'b0;
        addr_q          = '0;
        wait_cnt        = 0;
        forever begin
            @(posedge clk);
            if (rst_i) begin
                rd_addr_ready_o <= 1'b0;
                rd_data_valid_o <= 1'b0;
                pending         <= 1'b0;
            end else begin
                if (rd_addr_valid_i && rd_addr_ready_o) begin
                    pending         <= 1'b1;
                    addr_q          <= rd_addr_i;
                    wait_cnt        <= delay_i ? $urandom_range(4, 0) : 0;
                    rd_addr_ready_o <= 1'b0;
                end else begin
                    rd_addr_ready_o <= !pending && (!delay_i || $urandom_range(2, 0) == 0);
                end
                if (pending && !rd_data_valid_o) begin
                    if (wait_cnt == 0) begin
                        rd_data_valid_o <= 1'b1;
                        rd_data_o <= {mem[{addr_q[10:3], 1'b1}], mem[{addr_q[10:3], 1'b0}]};
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
                if (rd_data_valid_o && rd_data_ready_i) begin
                    rd_data_valid_o <= 1'b0;  // beat taken
                    pending         <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module rv_core_top (
    input  wire logic                clk,
    input  wire logic                rst_i,
    output logic                     rd_addr_valid_o,
    input  wire logic                rd_addr_ready_i,
    output logic [`RV_XLEN-1:0]      rd_addr_o,
    output logic [7:0]               rd_size_o,
    input  wire logic                rd_data_valid_i,
    output logic                     rd_data_ready_o,
    input  wire logic [`RV_XLEN-1:0] rd_data_i,
    output rv_core_pkg::retire_s     retire_o
);

    rv_core_pkg::fetch_out_s fetch_out;
    rv_core_pkg::dec_op_s    dec_op;
    rv_core_pkg::exe_res_s   exe_res;
    rv_core_pkg::redirect_s  redirect;
    logic [4:0]              rs1_addr;
    logic [4:0]              rs2_addr;
    logic [`RV_XLEN-1:0]     rs1_data;
    logic [`RV_XLEN-1:0]     rs2_data;

    rv_fetch i_fetch (
        .clk             (clk),
        .rst_i           (rst_i),
        .redirect_i      (redirect),
        .rd_addr_valid_o (rd_addr_valid_o),
        .rd_addr_ready_i (rd_addr_ready_i),
        .rd_addr_o       (rd_addr_o),
        .rd_size_o       (rd_size_o),
        .rd_data_valid_i (rd_data_valid_i),
        .rd_data_ready_o (rd_data_ready_o),
        .rd_data_i       (rd_data_i),
        .fetch_o         (fetch_out)
    );

    rv_decode i_decode (
        .clk     (clk),
        .rst_i   (rst_i),
        .fetch_i (fetch_out),
        .flush_i (redirect.valid),  // squash the fall-through slot
        .dec_o   (dec_op)
    );

    rv_execute i_execute (
        .clk        (clk),
        .rst_i      (rst_i),
        .dec_i      (dec_op),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .exe_o      (exe_res),
        .redirect_o (redirect)
    );

    rv_result i_result (
        .clk        (clk),
        .rst_i      (rst_i),
        .exe_i      (exe_res),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .retire_o   (retire_o)
    );

endmodule

`default_nettype wire

/* rv_result.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module rv_result (
    input  wire logic                  clk,
    input  wire logic                  rst_i,
    input  wire rv_core_pkg::exe_res_s exe_i,
    input  wire logic [4:0]            rs1_addr_i,
    input  wire logic [4:0]            rs2_addr_i,
    output logic [`RV_XLEN-1:0]        rs1_data_o,
    output logic [`RV_XLEN-1:0]        rs2_data_o,
    output rv_core_pkg::retire_s       retire_o
);

    logic [`RV_XLEN-1:0] regs [0:31];
    logic                wr_en;

    assign wr_en = exe_i.valid && exe_i.we && exe_i.rd != 5'd0;  // x0 never written

    always_ff @(posedge clk) begin
        if (!rst_i && wr_en) begin
            regs[exe_i.rd] <= exe_i.wdata;
        end
    end

    // x0 reads as zero
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

    always_comb begin
        retire_o.valid = exe_i.valid;
        retire_o.pc    = exe_i.pc;
        retire_o.rd    = wr_en ? exe_i.rd : 5'd0;     // report only real writes
        retire_o.wdata = wr_en ? exe_i.wdata : '0;
    end

endmodule

`default_nettype wire

/* rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module rv_execute (
    input  wire logic                 clk,
    input  wire logic                 rst_i,
    input  wire rv_core_pkg::dec_op_s dec_i,
    output logic [4:0]                rs1_addr_o,
    output logic [4:0]                rs2_addr_o,
    input  wire logic [`RV_XLEN-1:0]  rs1_data_i,
    input  wire logic [`RV_XLEN-1:0]  rs2_data_i,
    output rv_core_pkg::exe_res_s     exe_o,
    output rv_core_pkg::redirect_s    redirect_o
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] link;
    logic [`RV_XLEN-1:0] pc_rel;
    logic [`RV_XLEN-1:0] jalr_sum;
    logic                fwd_ok;
    logic                taken;
    logic [`RV_XLEN-1:0] target;
    rv_core_pkg::exe_res_s exe_c;
    rv_core_pkg::exe_res_s exe_q;
    logic                valid_q;

    assign rs1_addr_o = dec_i.rs1;
    assign rs2_addr_o = dec_i.rs2;

    // result register still one cycle ahead of the register file
    assign fwd_ok = exe_o.valid && exe_o.we && exe_o.rd != 5'd0;
    assign op_a   = (fwd_ok && exe_o.rd == dec_i.rs1) ? exe_o.wdata : rs1_data_i;
    assign op_b   = (fwd_ok && exe_o.rd == dec_i.rs2) ? exe_o.wdata : rs2_data_i;

    assign link     = dec_i.pc + 64'd4;
    assign pc_rel   = dec_i.pc + dec_i.imm;
    assign jalr_sum = op_a + dec_i.imm;

    always_comb begin
        exe_c       = '0;
        exe_c.valid = dec_i.valid;
        exe_c.pc    = dec_i.pc;
        exe_c.rd    = dec_i.rd;
        taken       = 1'b0;
        target      = pc_rel;
        case (dec_i.op)
            rv_core_pkg::OP_ADDI: begin
                exe_c.wdata = op_a + dec_i.imm;
                exe_c.we    = 1'b1;
            end
            rv_core_pkg::OP_ADD: begin
                exe_c.wdata = op_a + op_b;
                exe_c.we    = 1'b1;
            end
            rv_core_pkg::OP_SUB: begin
                exe_c.wdata = op_a - op_b;
                exe_c.we    = 1'b1;
            end
            rv_core_pkg::OP_LUI: begin
                exe_c.wdata = dec_i.imm;
                exe_c.we    = 1'b1;
            end
            rv_core_pkg::OP_JAL: begin
                exe_c.wdata = link;
                exe_c.we    = 1'b1;
                taken       = 1'b1;
            end
            rv_core_pkg::OP_JALR: begin
                exe_c.wdata = link;
                exe_c.we    = 1'b1;
                taken       = 1'b1;
                target      = {jalr_sum[`RV_XLEN-1:1], 1'b0};
            end
            rv_core_pkg::OP_BEQ: taken = (op_a == op_b);
            rv_core_pkg::OP_BNE: taken = (op_a != op_b);
            default: begin
                taken  = 1'b1;  // trap without a register write
                target = `RV_TRAP_VEC;
            end
        endcase
    end

    assign redirect_o = rv_core_pkg::redirect_s'{valid: dec_i.valid && taken, target: target};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dec_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_i.valid) exe_q <= exe_c;
    end

    always_comb begin
        exe_o       = exe_q;
        exe_o.valid = valid_q;
    end

    a_jalr_even: assert property (@(posedge clk) disable iff (rst_i)
        redirect_o.valid && dec_i.op == rv_core_pkg::OP_JALR |-> !redirect_o.target[0])
        else $error("jalr redirect target is odd");

endmodule

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module rv_decode (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire rv_core_pkg::fetch_out_s fetch_i,
    input  wire logic                   flush_i,
    output rv_core_pkg::dec_op_s        dec_o
);

    logic [31:0]         inst;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm_u;
    rv_core_pkg::dec_op_s dec_c;
    rv_core_pkg::dec_op_s dec_q;
    logic                valid_q;

    assign inst   = fetch_i.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // immediate formats
    assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_b = {{(`RV_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};

    always_comb begin
        dec_c       = '0;
        dec_c.valid = fetch_i.valid;
        dec_c.pc    = fetch_i.pc;
        dec_c.rd    = inst[11:7];
        dec_c.rs1   = inst[19:15];
        dec_c.rs2   = inst[24:20];
        dec_c.op    = rv_core_pkg::OP_ILLEGAL;
        dec_c.imm   = imm_i;
        case (opcode)
            7'b0010011: if (funct3 == 3'b000) dec_c.op = rv_core_pkg::OP_ADDI;
            7'b0110011: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) dec_c.op = rv_core_pkg::OP_ADD;
                if (funct3 == 3'b000 && funct7 == 7'b0100000) dec_c.op = rv_core_pkg::OP_SUB;
            end
            7'b0110111: begin
                dec_c.op  = rv_core_pkg::OP_LUI;
                dec_c.imm = imm_u;
            end
            7'b1101111: begin
                dec_c.op  = rv_core_pkg::OP_JAL;
                dec_c.imm = imm_j;
            end
            7'b1100111: if (funct3 == 3'b000) dec_c.op = rv_core_pkg::OP_JALR;
            7'b1100011: begin
                dec_c.imm = imm_b;
                if (funct3 == 3'b000) dec_c.op = rv_core_pkg::OP_BEQ;
                if (funct3 == 3'b001) dec_c.op = rv_core_pkg::OP_BNE;
            end
            default: dec_c.op = rv_core_pkg::OP_ILLEGAL;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            valid_q <= 1'b0;  // wrong-path instruction dropped
        end else begin
            valid_q <= fetch_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_i.valid) dec_q <= dec_c;
    end

    always_comb begin
        dec_o       = dec_q;
        dec_o.valid = valid_q;
    end

endmodule

`default_nettype wire

/* rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module rv_fetch (
    input  wire logic                  clk,
    input  wire logic                  rst_i,
    input  wire rv_core_pkg::redirect_s redirect_i,
    output logic                       rd_addr_valid_o,
    input  wire logic                  rd_addr_ready_i,
    output logic [`RV_XLEN-1:0]        rd_addr_o,
    output logic [7:0]                 rd_size_o,
    input  wire logic                  rd_data_valid_i,
    output logic                       rd_data_ready_o,
    input  wire logic [`RV_XLEN-1:0]   rd_data_i,
    output rv_core_pkg::fetch_out_s    fetch_o
);

    rv_core_pkg::fetch_state_e state;
    logic [`RV_XLEN-1:0] pc;       // next address to request
    logic                discard;  // outstanding beat is stale
    logic                out_valid;
    logic [`RV_XLEN-1:0] out_pc;
    logic [31:0]         out_inst;
    logic                beat;

    assign beat      = rd_data_valid_i && rd_data_ready_o;
    assign rd_size_o = `RV_FETCH_SIZE;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state           <= rv_core_pkg::FS_IDLE;
            pc              <= `RV_RESET_PC;
            discard         <= 1'b0;
            rd_addr_valid_o <= 1'b0;
            rd_data_ready_o <= 1'b0;
            out_valid       <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (redirect_i.valid) begin
                pc <= redirect_i.target;
            end
            case (state)
                rv_core_pkg::FS_IDLE: begin
                    rd_addr_valid_o <= 1'b1;
                    state           <= rv_core_pkg::FS_ADDR;
                end
                rv_core_pkg::FS_ADDR: begin
                    if (redirect_i.valid) discard <= 1'b1;
                    if (rd_addr_ready_i) begin
                        rd_addr_valid_o <= 1'b0;
                        rd_data_ready_o <= 1'b1;
                        state           <= rv_core_pkg::FS_DATA;
                    end
                end
                rv_core_pkg::FS_DATA: begin
                    if (beat) begin
                        rd_data_ready_o <= 1'b0;
                        discard         <= 1'b0;
                        state           <= rv_core_pkg::FS_IDLE;
                        if (!discard && !redirect_i.valid) begin
                            out_valid <= 1'b1;
                            pc        <= rd_addr_o + 64'd4;
                        end
                    end else if (redirect_i.valid) begin
                        discard <= 1'b1;
                    end
                end
                default: state <= rv_core_pkg::FS_IDLE;
            endcase
        end
    end

    // request address and instruction payload
    always_ff @(posedge clk) begin
        if (state == rv_core_pkg::FS_IDLE) begin
            rd_addr_o <= redirect_i.valid ? redirect_i.target : pc;
        end
        if (beat) begin
            out_pc   <= rd_addr_o;
            out_inst <= rd_addr_o[2] ? rd_data_i[63:32] : rd_data_i[31:0];  // word half
        end
    end

    assign fetch_o = rv_core_pkg::fetch_out_s'{valid: out_valid, pc: out_pc, inst: out_inst};

    a_addr_stable: assert property (@(posedge clk) disable iff (rst_i)
        rd_addr_valid_o && !rd_addr_ready_i |=> rd_addr_valid_o && $stable(rd_addr_o))
        else $error("fetch address changed before ready");

    a_no_ready_in_addr: assert property (@(posedge clk) disable iff (rst_i)
        state == rv_core_pkg::FS_ADDR |-> !rd_data_ready_o)
        else $error("data ready raised before address accepted");

endmodule

`default_nettype wire

/* rv_core_pkg.sv */
`default_nettype none
`include "rv_core_macros.svh"

package rv_core_pkg;

    // decoded operations, anything else traps
    typedef enum logic [3:0] {
        OP_ADDI,
        OP_ADD,
        OP_SUB,
        OP_LUI,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_ILLEGAL
    } op_e;

    typedef enum logic [1:0] {
        FS_IDLE,  // issue next address
        FS_ADDR,  // address valid, waiting for ready
        FS_DATA   // waiting for the data beat
    } fetch_state_e;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         inst;
    } fetch_out_s;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        op_e                 op;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] imm;  // already sign extended
    } dec_op_s;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] wdata;
        logic                we;
    } exe_res_s;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] target;
    } redirect_s;

    // one entry per retired instruction
    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;     // zero when nothing was written
        logic [`RV_XLEN-1:0] wdata;
    } retire_s;

endpackage

`default_nettype wire

/* rv_core_macros.svh */
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// data path width
`define RV_XLEN 64

// first fetch address after reset
`define RV_RESET_PC 64'h0000_0000_8000_0000

// redirect target for any illegal instruction
`define RV_TRAP_VEC 64'h0000_0000_8000_0400

// byte lanes of an instruction read request
`define RV_FETCH_SIZE 8'h0F

`endif
